/* rom_loader.f */
verilog/rom_loader_pkg.sv
verilog/dl_header_split.sv
verilog/dl_bank_router.sv
verilog/sdram_bank_mem.sv
verilog/prom_store.sv
verilog/rom_loader.sv
test/tb_rom_loader.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and decides pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f rom_loader.f --top-module tb_rom_loader -o tb_rom_loader \
    && ./obj_dir/tb_rom_loader > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1

/* test/tb_rom_loader.sv */
module tb_rom_loader;

    // header plus 0x400 body bytes covers all four banks and the PROM
    localparam int IMG_LEN = rom_loader_pkg::HEADER_LEN + 'h400;
    localparam int GAP = 7;
    localparam int TIMEOUT = 20;
    localparam int KIND_HDR = 0;
    localparam int KIND_SDRAM = 1;
    localparam int KIND_PROM = 2;

    logic                                       clk;
    logic                                       rst;
    logic                                       downloading;
    logic [rom_loader_pkg::ADDR_W-1:0]          ioctl_addr;
    logic [7:0]                                 ioctl_dout;
    logic                                       ioctl_wr;
    logic                                       header;
    logic [rom_loader_pkg::HEADER_LEN-1:0][7:0] header_bytes;
    logic [1:0]                                 rd_ba;
    logic [rom_loader_pkg::BANK_AW-1:0]         rd_addr;
    logic [15:0]                                rd_word;
    logic [rom_loader_pkg::PROM_AW-1:0]         prom_rd_addr;
    logic [7:0]                                 prom_rd_data;

    logic [31:0] lfsr;
    logic [7:0]  image [0:IMG_LEN-1];
    logic [15:0] exp_bank [0:3][0:rom_loader_pkg::BANK_WORDS-1];
    logic [7:0]  exp_prom [0:rom_loader_pkg::PROM_BYTES-1];
    int          errors;
    int          checks;
    int          hdr_cycles;

    rom_loader dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit, the fresh feedback bit is the one taken
    task automatic next_rand_byte(output logic [7:0] val);
        val = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[6:0], lfsr[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // reference model of the region map
    //////////////////////////////////////////////////

    // an image index lands in a header slot, a bank word lane or a PROM byte;
    // even bytes fill the upper lane unless the byte order is swapped
    function automatic void place_of(input int idx, output int kind, output int bank,
                                     output int word, output bit hi, output int pidx);
        int off;
        int base;
        bit odd;
        off = idx - rom_loader_pkg::HEADER_LEN;
        bank = 0;
        base = 0;
        word = 0;
        hi = 1'b0;
        pidx = 0;
        if (idx < rom_loader_pkg::HEADER_LEN) begin
            kind = KIND_HDR;
        end else if (off >= int'(rom_loader_pkg::PROM_START)) begin
            kind = KIND_PROM;
            pidx = off - int'(rom_loader_pkg::PROM_START);
        end else begin
            kind = KIND_SDRAM;
            if (off >= int'(rom_loader_pkg::BA3_START)) begin
                bank = 3;
                base = int'(rom_loader_pkg::BA3_START);
            end else if (off >= int'(rom_loader_pkg::BA2_START)) begin
                bank = 2;
                base = int'(rom_loader_pkg::BA2_START);
            end else if (off >= int'(rom_loader_pkg::BA1_START)) begin
                bank = 1;
                base = int'(rom_loader_pkg::BA1_START);
            end
            word = (off - base) / 2;
            odd = ((off - base) % 2) != 0;
            hi = (odd == rom_loader_pkg::SWAB);
        end
    endfunction

    //////////////////////////////////////////////////
    // drivers and readers
    //////////////////////////////////////////////////

    // a one-cycle strobe, then the rest of the 7-cycle slot; SDRAM bytes must see
    // their acknowledge inside that slot
    task automatic send_byte(input int addr, input logic [7:0] val, input bit want_ack);
        int cycles;
        bit acked;
        cycles = 1;
        acked = 1'b0;
        @(negedge clk);
        ioctl_addr = rom_loader_pkg::ADDR_W'(addr);
        ioctl_dout = val;
        ioctl_wr = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (want_ack && !acked && cycles < TIMEOUT) begin
            if (dut0.sdram_ack === 1'b1) begin
                acked = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (want_ack && !acked) begin
            errors++;
            $display("timed out waiting for the SDRAM acknowledge of address %0h", addr);
        end
        while (cycles < GAP - 1) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((dut0.prog_we !== 1'b0 || dut0.prom_we !== 1'b0 || dut0.hs_wr !== 1'b0)
               && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            errors++;
            $display("timed out waiting for the pipeline to go idle after the download");
        end
    endtask

    task automatic read_word(input int bank, input int word, output logic [15:0] val);
        @(negedge clk);
        rd_ba = 2'(bank);
        rd_addr = rom_loader_pkg::BANK_AW'(word);
        @(negedge clk);
        val = rd_word;
    endtask

    task automatic read_prom(input int idx, output logic [7:0] val);
        @(negedge clk);
        prom_rd_addr = rom_loader_pkg::PROM_AW'(idx);
        @(negedge clk);
        val = prom_rd_data;
    endtask

    //////////////////////////////////////////////////
    // comparisons
    //////////////////////////////////////////////////

    // both lanes are compared, so a second write that clobbers the first byte shows here
    task automatic check_bank_word(input int bank, input int word, input logic [15:0] exp);
        logic [15:0] got;
        read_word(bank, word, got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: bank %0d word %0d reads %h, expected %h",
                     $time, bank, word, got, exp);
        end
    endtask

    task automatic check_prom_byte(input int idx, input logic [7:0] exp);
        logic [7:0] got;
        read_prom(idx, got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: PROM byte %0d reads %h, expected %h", $time, idx, got, exp);
        end
    endtask

    // header only depends on the port, which is steady by the rising edge
    always @(posedge clk) begin : header_check
        int kind;
        int bank;
        int word;
        bit hi;
        int pidx;
        bit exp_hdr;
        if (!rst) begin
            place_of(int'(ioctl_addr), kind, bank, word, hi, pidx);
            exp_hdr = downloading && (kind == KIND_HDR);
            checks++;
            if (header !== exp_hdr) begin
                errors++;
                $display("FAIL t=%0t: header is %b at address %0h with downloading %b",
                         $time, header, ioctl_addr, downloading);
            end
            if (header === 1'b1) begin
                hdr_cycles++;
            end
        end
    end

    initial begin
        int kind;
        int bank;
        int word;
        bit hi;
        int pidx;
        logic [7:0] val;
        errors = 0;
        checks = 0;
        hdr_cycles = 0;
        rst = 1'b1;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        rd_ba = '0;
        rd_addr = '0;
        prom_rd_addr = '0;
        lfsr = 32'h5f1e;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // the stores start cleared, so untouched words must stay zero
        for (int b = 0; b < 4; b++) begin
            for (int w = 0; w < rom_loader_pkg::BANK_WORDS; w++) begin
                exp_bank[b][w] = '0;
            end
        end
        for (int p = 0; p < rom_loader_pkg::PROM_BYTES; p++) begin
            exp_prom[p] = '0;
        end
        for (int i = 0; i < IMG_LEN; i++) begin
            next_rand_byte(val);
            image[i] = val;
            place_of(i, kind, bank, word, hi, pidx);
            if (kind == KIND_SDRAM && hi) begin
                exp_bank[bank][word][15:8] = val;
            end else if (kind == KIND_SDRAM) begin
                exp_bank[bank][word][7:0] = val;
            end else if (kind == KIND_PROM) begin
                exp_prom[pidx] = val;
            end
        end

        //////////////////////////////////////////////////
        // full download
        //////////////////////////////////////////////////
        @(negedge clk);
        downloading = 1'b1;
        for (int i = 0; i < IMG_LEN; i++) begin
            place_of(i, kind, bank, word, hi, pidx);
            send_byte(i, image[i], kind == KIND_SDRAM);
        end
        wait_idle();
        @(negedge clk);
        downloading = 1'b0;

        for (int i = 0; i < rom_loader_pkg::HEADER_LEN; i++) begin
            checks++;
            if (header_bytes[i] !== image[i]) begin
                errors++;
                $display("FAIL t=%0t: header byte %0d is %h, expected %h",
                         $time, i, header_bytes[i], image[i]);
            end
        end
        for (int b = 0; b < 4; b++) begin
            for (int w = 0; w < rom_loader_pkg::BANK_WORDS; w++) begin
                check_bank_word(b, w, exp_bank[b][w]);
            end
        end
        for (int p = 0; p < rom_loader_pkg::PROM_BYTES; p++) begin
            check_prom_byte(p, exp_prom[p]);
        end

        // writes with downloading low hit a bank word, a PROM byte and a header slot
        send_byte(rom_loader_pkg::HEADER_LEN, ~image[rom_loader_pkg::HEADER_LEN], 1'b0);
        send_byte(rom_loader_pkg::HEADER_LEN + 1, ~image[rom_loader_pkg::HEADER_LEN + 1], 1'b0);
        send_byte(rom_loader_pkg::HEADER_LEN + int'(rom_loader_pkg::PROM_START),
                  ~image[rom_loader_pkg::HEADER_LEN + int'(rom_loader_pkg::PROM_START)], 1'b0);
        send_byte(0, ~image[0], 1'b0);
        check_bank_word(0, 0, exp_bank[0][0]);
        check_prom_byte(0, exp_prom[0]);
        checks++;
        if (header_bytes[0] !== image[0]) begin
            errors++;
            $display("FAIL t=%0t: header byte 0 changed to %h outside a download",
                     $time, header_bytes[0]);
        end
        if (hdr_cycles == 0) begin
            errors++;
            $display("the header flag never went high during the download");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/dl_bank_router.sv */
module dl_bank_router (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                downloading,
    input  logic                                hs_wr,
    input  logic [rom_loader_pkg::ADDR_W-1:0]   hs_addr,
    input  logic [7:0]                          hs_data,
    input  logic                                sdram_ack,
    output logic [rom_loader_pkg::PROG_AW-1:0]  prog_addr,
    output logic [15:0]                         prog_data,
    output logic [1:0]                          prog_mask,
    output logic [1:0]                          prog_ba,
    output logic                                prog_we,
    output logic                                prom_we,
    output logic [rom_loader_pkg::PROM_AW-1:0]  prom_addr,
    output logic [7:0]                          prom_data
);

    logic [1:0]                        bank;
    logic [rom_loader_pkg::ADDR_W-1:0] bank_base;
    logic [rom_loader_pkg::ADDR_W-1:0] prom_off;
    logic                              is_prom;
    rom_loader_pkg::dl_addr_u          eff;

    //////////////////////////////////////////////////
    // region decode
    //////////////////////////////////////////////////

    // the PROM region sits above all banks, so it wins over bank 3
    assign is_prom  = hs_addr >= rom_loader_pkg::PROM_START;
    assign prom_off = hs_addr - rom_loader_pkg::PROM_START;

    // banks are checked from the top down, the first bound passed picks the bank
    always_comb begin
        if (hs_addr >= rom_loader_pkg::BA3_START) begin
            bank = 2'd3;
        end else if (hs_addr >= rom_loader_pkg::BA2_START) begin
            bank = 2'd2;
        end else if (hs_addr >= rom_loader_pkg::BA1_START) begin
            bank = 2'd1;
        end else begin
            bank = 2'd0;
        end
        case (bank)
            2'd1:    bank_base = rom_loader_pkg::BA1_START;
            2'd2:    bank_base = rom_loader_pkg::BA2_START;
            2'd3:    bank_base = rom_loader_pkg::BA3_START;
            default: bank_base = '0;
        endcase
        // offset inside the bank, the word view of it drives the SDRAM bus
        eff.flat = hs_addr - bank_base;
    end

    //////////////////////////////////////////////////
    // request generation
    //////////////////////////////////////////////////

    // prog_we is a level held until the SDRAM takes the word, while
    // prom_we lasts a single cycle per byte
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else if (hs_wr && downloading) begin
            prog_we <= !is_prom;
            prom_we <= is_prom;
        end else begin
            prom_we <= 1'b0;
            if (sdram_ack || !downloading) begin
                prog_we <= 1'b0;
            end
        end
    end

    // even bytes go to the upper lane unless the byte order is swapped
    always_ff @(posedge clk) begin
        if (hs_wr && downloading) begin
            if (is_prom) begin
                prom_addr <= prom_off[rom_loader_pkg::PROM_AW-1:0];
                prom_data <= hs_data;
            end else begin
                prog_addr <= eff.word.idx[rom_loader_pkg::PROG_AW-1:0];
                prog_ba   <= bank;
                prog_data <= {2{hs_data}};
                prog_mask <= (eff.word.sel ^ rom_loader_pkg::SWAB) ? 2'b10 : 2'b01;
            end
        end
    end

endmodule

/* verilog/dl_header_split.sv */
module dl_header_split (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      downloading,
    input  logic [rom_loader_pkg::ADDR_W-1:0]         ioctl_addr,
    input  logic [7:0]                                ioctl_dout,
    input  logic                                      ioctl_wr,
    output logic                                      header,
    output logic [rom_loader_pkg::HEADER_LEN-1:0][7:0] header_bytes,
    output logic                                      hs_wr,
    output logic [rom_loader_pkg::ADDR_W-1:0]         hs_addr,
    output logic [7:0]                                hs_data
);

    logic take;

    // the header flag follows the port directly, it is not registered
    // and drops as soon as the download ends
    assign header = downloading
                    && (ioctl_addr < rom_loader_pkg::ADDR_W'(rom_loader_pkg::HEADER_LEN));

    // a byte moves down the pipeline only if it is part of the image body
    assign take = ioctl_wr && downloading && !header;

    //////////////////////////////////////////////////
    // header capture
    //////////////////////////////////////////////////

    // each header byte lands in the slot given by its own address, so the
    // cores can read things like the board type after the download
    always_ff @(posedge clk) begin
        if (ioctl_wr && header) begin
            header_bytes[ioctl_addr[rom_loader_pkg::HDR_IW-1:0]] <= ioctl_dout;
        end
    end

    //////////////////////////////////////////////////
    // body bytes
    //////////////////////////////////////////////////

    // the strobe is one cycle long because ioctl_wr is
    always_ff @(posedge clk) begin
        if (rst) begin
            hs_wr <= 1'b0;
        end else begin
            hs_wr <= take;
        end
    end

    // from here on addresses count from the first byte after the header
    always_ff @(posedge clk) begin
        if (take) begin
            hs_addr <= ioctl_addr - rom_loader_pkg::ADDR_W'(rom_loader_pkg::HEADER_LEN);
            hs_data <= ioctl_dout;
        end
    end

endmodule

/* verilog/prom_store.sv */
module prom_store (
    input  logic                                clk,
    input  logic                                prom_we,
    input  logic [rom_loader_pkg::PROM_AW-1:0]  prom_addr,
    input  logic [7:0]                          prom_data,
    input  logic [rom_loader_pkg::PROM_AW-1:0]  prom_rd_addr,
    output logic [7:0]                          prom_rd_data
);

    logic [7:0] mem [0:rom_loader_pkg::PROM_BYTES-1];

    // starts blank so unwritten locations read back as zero
    initial begin
        for (int i = 0; i < rom_loader_pkg::PROM_BYTES; i++) begin
            mem[i] = '0;
        end
    end

    // one byte per prom_we pulse
    always_ff @(posedge clk) begin
        if (prom_we) begin
            mem[prom_addr] <= prom_data;
        end
    end

    // the read side is asynchronous, like the LUT based PROMs in the cores
    assign prom_rd_data = mem[prom_rd_addr];

endmodule

/* verilog/rom_loader.sv */
module rom_loader (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       downloading,
    input  logic [rom_loader_pkg::ADDR_W-1:0]          ioctl_addr,
    input  logic [7:0]                                 ioctl_dout,
    input  logic                                       ioctl_wr,
    output logic                                       header,
    output logic [rom_loader_pkg::HEADER_LEN-1:0][7:0] header_bytes,
    input  logic [1:0]                                 rd_ba,
    input  logic [rom_loader_pkg::BANK_AW-1:0]         rd_addr,
    output logic [15:0]                                rd_word,
    input  logic [rom_loader_pkg::PROM_AW-1:0]         prom_rd_addr,
    output logic [7:0]                                 prom_rd_data
);

    //////////////////////////////////////////////////
    // stage 1 to stage 2
    //////////////////////////////////////////////////

    logic                              hs_wr;
    logic [rom_loader_pkg::ADDR_W-1:0] hs_addr;
    logic [7:0]                        hs_data;

    //////////////////////////////////////////////////
    // stage 2 to the stores
    //////////////////////////////////////////////////

    logic [rom_loader_pkg::PROG_AW-1:0] prog_addr;
    logic [15:0]                        prog_data;
    logic [1:0]                         prog_mask;
    logic [1:0]                         prog_ba;
    logic                               prog_we;
    logic                               sdram_ack;
    logic                               prom_we;
    logic [rom_loader_pkg::PROM_AW-1:0] prom_addr;
    logic [7:0]                         prom_data;

    // strips the header and registers the body bytes
    dl_header_split u_split (
        .clk          (clk),
        .rst          (rst),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .ioctl_wr     (ioctl_wr),
        .header       (header),
        .header_bytes (header_bytes),
        .hs_wr        (hs_wr),
        .hs_addr      (hs_addr),
        .hs_data      (hs_data)
    );

    // the download level also reaches the router, which uses it to drop requests
    dl_bank_router u_router (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .hs_wr       (hs_wr),
        .hs_addr     (hs_addr),
        .hs_data     (hs_data),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data)
    );

    sdram_bank_mem u_sdram (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_mask (prog_mask),
        .prog_ba   (prog_ba),
        .sdram_ack (sdram_ack),
        .rd_ba     (rd_ba),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word)
    );

    prom_store u_prom (
        .clk          (clk),
        .prom_we      (prom_we),
        .prom_addr    (prom_addr),
        .prom_data    (prom_data),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data)
    );

endmodule

/* verilog/rom_loader_pkg.sv */
package rom_loader_pkg;

    //////////////////////////////////////////////////
    // download port
    //////////////////////////////////////////////////

    // byte address of the ioctl port, enough for a 32 MB image
    localparam int ADDR_W = 25;
    // the image starts with a header that never reaches the stores
    localparam int HEADER_LEN = 16;
    localparam int HDR_IW = $clog2(HEADER_LEN);

    //////////////////////////////////////////////////
    // region map, offsets counted after the header
    //////////////////////////////////////////////////

    // bank 0 starts at offset zero and each later bank starts at its own bound
    localparam logic [ADDR_W-1:0] BA1_START = 25'h100;
    localparam logic [ADDR_W-1:0] BA2_START = 25'h200;
    localparam logic [ADDR_W-1:0] BA3_START = 25'h300;
    // everything from here to the end of the image is PROM data
    localparam logic [ADDR_W-1:0] PROM_START = 25'h380;
    // set to swap the two bytes of every SDRAM word
    localparam logic SWAB = 1'b0;

    //////////////////////////////////////////////////
    // stores
    //////////////////////////////////////////////////

    // word address width on the SDRAM programming bus
    localparam int PROG_AW = 22;
    localparam int BANK_WORDS = 128;
    localparam int BANK_AW = $clog2(BANK_WORDS);
    localparam int BANK_BYTES = 2 * BANK_WORDS;
    localparam int PROM_BYTES = 128;
    localparam int PROM_AW = $clog2(PROM_BYTES);
    // cycles from the first cycle of a request to the acknowledge
    localparam int ACK_DELAY = 2;
    localparam int ACK_CW = $clog2(ACK_DELAY + 1);

    // a byte offset seen either flat or as a 16-bit word index plus byte select
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [ADDR_W-2:0] idx;
            logic              sel;
        } word;
    } dl_addr_u;

endpackage

/* verilog/sdram_bank_mem.sv */
module sdram_bank_mem (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                prog_we,
    input  logic [rom_loader_pkg::PROG_AW-1:0]  prog_addr,
    input  logic [15:0]                         prog_data,
    input  logic [1:0]                          prog_mask,
    input  logic [1:0]                          prog_ba,
    output logic                                sdram_ack,
    input  logic [1:0]                          rd_ba,
    input  logic [rom_loader_pkg::BANK_AW-1:0]  rd_addr,
    output logic [15:0]                         rd_word
);

    logic [15:0] mem [0:3][0:rom_loader_pkg::BANK_WORDS-1];
    logic [rom_loader_pkg::ACK_CW-1:0] ack_cnt;
    rom_loader_pkg::dl_addr_u          wr_a;
    logic                              in_range;
    logic                              wr_now;

    // the banks come up empty, as the SDRAM is cleared before a download
    initial begin
        for (int b = 0; b < 4; b++) begin
            for (int w = 0; w < rom_loader_pkg::BANK_WORDS; w++) begin
                mem[b][w] = '0;
            end
        end
    end

    // rebuild the byte offset inside the bank from the word address and the lane,
    // anything past the modelled part of the bank is dropped
    always_comb begin
        wr_a.word.idx = {{(rom_loader_pkg::ADDR_W - 1 - rom_loader_pkg::PROG_AW){1'b0}},
                         prog_addr};
        wr_a.word.sel = prog_mask[1] ^ rom_loader_pkg::SWAB;
        in_range = wr_a.flat < rom_loader_pkg::ADDR_W'(rom_loader_pkg::BANK_BYTES);
    end

    //////////////////////////////////////////////////
    // acknowledge timing
    //////////////////////////////////////////////////

    // the counter runs from the first cycle of the request and stops once
    // it has fired, it only rearms after prog_we goes low
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_cnt   <= '0;
            sdram_ack <= 1'b0;
        end else begin
            sdram_ack <= 1'b0;
            if (!prog_we) begin
                ack_cnt <= '0;
            end else if (ack_cnt != rom_loader_pkg::ACK_CW'(rom_loader_pkg::ACK_DELAY)) begin
                ack_cnt <= ack_cnt + rom_loader_pkg::ACK_CW'(1);
                if (wr_now) begin
                    sdram_ack <= 1'b1;
                end
            end
        end
    end

    // the word is written on the same edge that raises the acknowledge
    assign wr_now = prog_we
                    && (ack_cnt == rom_loader_pkg::ACK_CW'(rom_loader_pkg::ACK_DELAY - 1));

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    // mask bits are active low, one per byte lane
    always_ff @(posedge clk) begin
        if (wr_now && in_range) begin
            if (!prog_mask[0]) begin
                mem[prog_ba][wr_a.word.idx[rom_loader_pkg::BANK_AW-1:0]][7:0] <= prog_data[7:0];
            end
            if (!prog_mask[1]) begin
                mem[prog_ba][wr_a.word.idx[rom_loader_pkg::BANK_AW-1:0]][15:8] <= prog_data[15:8];
            end
        end
    end

    assign rd_word = mem[rd_ba][rd_addr];

endmodule
